/* controlUnit.f */
+incdir+include
source/cu_pkg.sv
source/instrDecoder.sv
source/microSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
testbench/controlUnit_sva.sv
testbench/controlUnitTb.sv

/* include/cu_params.svh */
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Control field widths
`define INS_WIDTH 8
`define WEN_WIDTH 13
`define BUS_WIDTH 4
`define INC_WIDTH 6
`define RST_WIDTH 5
`define CMP_WIDTH 3
`define ALU_WIDTH 3

// Register write enables
`define WEN_PC  12
`define WEN_IR  11
`define WEN_AR  10
`define WEN_DR  9
`define WEN_RP  8
`define WEN_RT  7
`define WEN_RM1 6
`define WEN_RK1 5
`define WEN_RN1 4
`define WEN_C1  3
`define WEN_C2  2
`define WEN_C3  1
`define WEN_AC  0

// Bus sources
`define BUS_MEM  4'd15
`define BUS_AR   4'd14
`define BUS_DR   4'd13
`define BUS_RP   4'd12
`define BUS_RT   4'd11
`define BUS_RM1  4'd10
`define BUS_RM2  4'd7
`define BUS_C1   4'd4
`define BUS_C2   4'd3
`define BUS_C3   4'd2
`define BUS_AC   4'd1
`define BUS_NONE 4'd0

// Increment bits
`define INC_PC 5
`define INC_M2 4
`define INC_K2 3
`define INC_N2 2
`define INC_C2 1
`define INC_C3 0

// Register reset bits
`define RST_RT 4
`define RST_M2 3
`define RST_K2 2
`define RST_N2 1
`define RST_AC 0

// Compare pair select, same code for both muxes
`define CMP_M 2
`define CMP_K 1
`define CMP_N 0

`endif

/* run.sh */
#!/bin/sh
# Verilator build and run of the control unit testbench

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module controlUnitTb \
    -Mdir "$BUILD_DIR" \
    -f controlUnit.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/VcontrolUnitTb" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST OK" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

/* source/controlUnit.sv */
`timescale 1ns/100ps
`include "cu_params.svh"

module controlUnit (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  z,
    input  logic [`INS_WIDTH-1:0] ins,
    output logic                  iromRead,
    output logic                  memRead,
    output logic                  memWrite,
    output logic [`WEN_WIDTH-1:0] wEn,
    output logic                  selAr,
    output logic [`BUS_WIDTH-1:0] busSel,
    output logic [`INC_WIDTH-1:0] inc,
    output logic [`RST_WIDTH-1:0] rst,
    output logic [`CMP_WIDTH-1:0] cmpSel,
    output cu_pkg::aluOpT         aluOp
);
    import cu_pkg::*;

    cuStateT dispatchState;
    cuStateT variantState;
    cuStateT state;

    instrDecoder uDecoder (
        .ins           (ins),
        .dispatchState (dispatchState),
        .variantState  (variantState)
    );

    microSequencer uSequencer (
        .Clk           (Clk),
        .rstN          (rstN),
        .z             (z),
        .dispatchState (dispatchState),
        .variantState  (variantState),
        .state         (state)
    );

    controlWordGen uWordGen (
        .state    (state),
        .iromRead (iromRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .selAr    (selAr),
        .wEn      (wEn),
        .busSel   (busSel),
        .inc      (inc),
        .rst      (rst),
        .cmpSel   (cmpSel),
        .aluOp    (aluOp)
    );

endmodule

/* source/controlWordGen.sv */
`timescale 1ns/100ps
`include "cu_params.svh"

module controlWordGen (
    input  cu_pkg::cuStateT       state,
    output logic                  iromRead,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  selAr,
    output logic [`WEN_WIDTH-1:0] wEn,
    output logic [`BUS_WIDTH-1:0] busSel,
    output logic [`INC_WIDTH-1:0] inc,
    output logic [`RST_WIDTH-1:0] rst,
    output logic [`CMP_WIDTH-1:0] cmpSel,
    output cu_pkg::aluOpT         aluOp
);
    import cu_pkg::*;

    always_comb begin
        iromRead = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        selAr    = 1'b0;
        wEn      = '0;
        busSel   = `BUS_NONE;
        inc      = '0;
        rst      = '0;
        cmpSel   = '0;
        aluOp    = aluNone;

        case (state)
            stFetch1: iromRead = 1'b1;
            stFetch2: begin    // IR <= IROM[PC], PC <= PC + 1
                wEn[`WEN_IR] = 1'b1;
                inc[`INC_PC] = 1'b1;
            end

            stJmpM: cmpSel[`CMP_M] = 1'b1;    // M1 - M2
            stJmpK: cmpSel[`CMP_K] = 1'b1;
            stJmpN: cmpSel[`CMP_N] = 1'b1;
            stJmp2: iromRead = 1'b1;
            stJmp3: begin    // AR <= IROM[PC]
                wEn[`WEN_AR] = 1'b1;
                selAr = 1'b1;
            end
            stJmp4: begin    // PC <= AR
                wEn[`WEN_PC] = 1'b1;
                busSel = `BUS_AR;
            end
            stNoJmp: inc[`INC_PC] = 1'b1;

            stCopy1: iromRead = 1'b1;
            stCopy2: begin    // AR <= IROM[PC], PC <= PC + 1
                wEn[`WEN_AR] = 1'b1;
                selAr = 1'b1;
                inc[`INC_PC] = 1'b1;
            end
            stCopy3: memRead = 1'b1;
            stCopy4: begin    // DR <= MEM[AR]
                wEn[`WEN_DR] = 1'b1;
                busSel = `BUS_MEM;
            end
            stCopyM: begin
                wEn[`WEN_RM1] = 1'b1;
                busSel = `BUS_DR;
            end
            stCopyK: begin
                wEn[`WEN_RK1] = 1'b1;
                busSel = `BUS_DR;
            end
            stCopyN: begin
                wEn[`WEN_RN1] = 1'b1;
                busSel = `BUS_DR;
            end

            stLoadC1: begin    // AR <= C1
                wEn[`WEN_AR] = 1'b1;
                busSel = `BUS_C1;
            end
            stLoadC2: begin
                wEn[`WEN_AR] = 1'b1;
                busSel = `BUS_C2;
            end
            stLoad2: memRead = 1'b1;
            stLoad3: begin
                wEn[`WEN_DR] = 1'b1;
                busSel = `BUS_MEM;
            end

            stStore1: begin    // DR <= RT
                wEn[`WEN_DR] = 1'b1;
                busSel = `BUS_RT;
            end
            stStore2: begin    // AR <= C3
                wEn[`WEN_AR] = 1'b1;
                busSel = `BUS_C3;
            end
            stStore3: begin    // MEM[AR] <= DR
                memWrite = 1'b1;
                busSel = `BUS_DR;
            end

            stAssign1: iromRead = 1'b1;
            stAssign2: begin    // Immediate word into AR
                wEn[`WEN_AR] = 1'b1;
                selAr = 1'b1;
                inc[`INC_PC] = 1'b1;
            end
            stAssignC1: begin
                wEn[`WEN_C1] = 1'b1;
                busSel = `BUS_AR;
            end
            stAssignC2: begin
                wEn[`WEN_C2] = 1'b1;
                busSel = `BUS_AR;
            end
            stAssignC3: begin
                wEn[`WEN_C3] = 1'b1;
                busSel = `BUS_AR;
            end

            stResetAll: begin
                rst[`RST_RT] = 1'b1;
                rst[`RST_M2] = 1'b1;
                rst[`RST_K2] = 1'b1;
                rst[`RST_N2] = 1'b1;
                rst[`RST_AC] = 1'b1;
            end
            stResetN2: rst[`RST_N2] = 1'b1;
            stResetK2: rst[`RST_K2] = 1'b1;

            // AC out to P, T or C1
            stMoveP: begin
                wEn[`WEN_RP] = 1'b1;
                busSel = `BUS_AC;
            end
            stMoveT: begin
                wEn[`WEN_RT] = 1'b1;
                busSel = `BUS_AC;
            end
            stMoveC1: begin
                wEn[`WEN_C1] = 1'b1;
                busSel = `BUS_AC;
            end

            // ALU ops, result always lands in AC
            stSetC1: begin
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_C1;
                aluOp = aluSet;
            end
            stSetDr: begin
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_DR;
                aluOp = aluSet;
            end
            stMul: begin    // AC <= P * AC
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_RP;
                aluOp = aluMul;
            end
            stAddRt: begin
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_RT;
                aluOp = aluAdd;
            end
            stAddRm1: begin
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_RM1;
                aluOp = aluAdd;
            end
            stAddRm2: begin
                wEn[`WEN_AC] = 1'b1;
                busSel = `BUS_RM2;
                aluOp = aluAdd;
            end

            stIncC2: inc[`INC_C2] = 1'b1;
            stIncC3: inc[`INC_C3] = 1'b1;
            stIncM2: inc[`INC_M2] = 1'b1;
            stIncK2: inc[`INC_K2] = 1'b1;
            stIncN2: inc[`INC_N2] = 1'b1;

            // Noop and decode cycle keep the all-zero word
            default: ;
        endcase
    end

endmodule

/* source/cu_pkg.sv */
`include "cu_params.svh"

package cu_pkg;

    // One state per cycle of every instruction
    typedef enum logic [7:0] {
        stNoop, stFetch1, stFetch2, stFetch3,
        stJmpM, stJmpK, stJmpN, stJmp2, stJmp3, stJmp4, stNoJmp,
        stCopy1, stCopy2, stCopy3, stCopy4, stCopyM, stCopyK, stCopyN,
        stLoadC1, stLoadC2, stLoad2, stLoad3,
        stStore1, stStore2, stStore3,
        stAssign1, stAssign2, stAssignC1, stAssignC2, stAssignC3,
        stResetAll, stResetN2, stResetK2,
        stMoveP, stMoveT, stMoveC1,
        stSetC1, stSetDr, stMul,
        stAddRt, stAddRm1, stAddRm2,
        stIncC2, stIncC3, stIncM2, stIncK2, stIncN2
    } cuStateT;

    // Instruction bits 7..4
    typedef enum logic [3:0] {
        opNoop = 4'd0, opJmp = 4'd1, opCopy = 4'd2, opLoad = 4'd3,
        opStore = 4'd4, opAssign = 4'd5, opReset = 4'd6, opMove = 4'd7,
        opSet = 4'd8, opMul = 4'd9, opAdd = 4'd10, opInc = 4'd11
    } opcodeT;

    // Instruction bits 3..0, one set per opcode group
    typedef enum logic [3:0] {jmpM, jmpK, jmpN} jmpSubT;
    typedef enum logic [3:0] {copyM1, copyK1, copyN1} copySubT;
    typedef enum logic [3:0] {loadC1, loadC2} loadSubT;
    typedef enum logic [3:0] {assignC1, assignC2, assignC3} assignSubT;
    typedef enum logic [3:0] {resetAll, resetN2, resetK2} resetSubT;
    typedef enum logic [3:0] {moveP, moveT, moveC1} moveSubT;
    typedef enum logic [3:0] {setC1, setDr} setSubT;
    typedef enum logic [3:0] {addRt, addRm1, addRm2} addSubT;
    typedef enum logic [3:0] {incC2, incC3, incM2, incK2, incN2} incSubT;

    // One-hot ALU operation
    typedef enum logic [`ALU_WIDTH-1:0] {
        aluNone = 3'b000, aluSet = 3'b001, aluMul = 3'b010, aluAdd = 3'b100
    } aluOpT;

endpackage

/* source/instrDecoder.sv */
`timescale 1ns/100ps
`include "cu_params.svh"

module instrDecoder (
    input  logic [`INS_WIDTH-1:0] ins,
    output cu_pkg::cuStateT       dispatchState,
    output cu_pkg::cuStateT       variantState
);
    import cu_pkg::*;

    opcodeT     opcode;
    logic [3:0] sub;
    logic [3:0] lowSel;    // Target pick for copy and assign

    assign opcode = opcodeT'(ins[7:4]);
    assign sub    = ins[3:0];
    assign lowSel = {2'b00, ins[1:0]};

    // First execution state after the fetch cycles
    always_comb begin
        dispatchState = stNoop;
        case (opcode)
            opNoop: dispatchState = stNoop;
            opJmp: begin
                case (sub)
                    jmpM:    dispatchState = stJmpM;
                    jmpK:    dispatchState = stJmpK;
                    jmpN:    dispatchState = stJmpN;
                    default: dispatchState = stNoop;
                endcase
            end
            opCopy:   dispatchState = (sub <= copyN1) ? stCopy1 : stNoop;
            opLoad: begin
                case (sub)
                    loadC1:  dispatchState = stLoadC1;
                    loadC2:  dispatchState = stLoadC2;
                    default: dispatchState = stNoop;
                endcase
            end
            opStore:  dispatchState = (sub == 4'h0) ? stStore1 : stNoop;
            opAssign: dispatchState = (sub <= assignC3) ? stAssign1 : stNoop;
            opReset: begin
                case (sub)
                    resetAll: dispatchState = stResetAll;
                    resetN2:  dispatchState = stResetN2;
                    resetK2:  dispatchState = stResetK2;
                    default:  dispatchState = stNoop;
                endcase
            end
            opMove: begin
                case (sub)
                    moveP:   dispatchState = stMoveP;
                    moveT:   dispatchState = stMoveT;
                    moveC1:  dispatchState = stMoveC1;
                    default: dispatchState = stNoop;
                endcase
            end
            opSet: begin
                case (sub)
                    setC1:   dispatchState = stSetC1;
                    setDr:   dispatchState = stSetDr;
                    default: dispatchState = stNoop;
                endcase
            end
            opMul:    dispatchState = (sub == 4'h0) ? stMul : stNoop;
            opAdd: begin
                case (sub)
                    addRt:   dispatchState = stAddRt;
                    addRm1:  dispatchState = stAddRm1;
                    addRm2:  dispatchState = stAddRm2;
                    default: dispatchState = stNoop;
                endcase
            end
            opInc: begin
                case (sub)
                    incC2:   dispatchState = stIncC2;
                    incC3:   dispatchState = stIncC3;
                    incM2:   dispatchState = stIncM2;
                    incK2:   dispatchState = stIncK2;
                    incN2:   dispatchState = stIncN2;
                    default: dispatchState = stNoop;
                endcase
            end
            default: dispatchState = stNoop;
        endcase
    end

    // Last step of copy or assign, taken after stCopy4 or stAssign2
    always_comb begin
        variantState = stNoop;
        if (opcode == opAssign) begin
            case (lowSel)
                assignC1: variantState = stAssignC1;
                assignC2: variantState = stAssignC2;
                assignC3: variantState = stAssignC3;
                default:  variantState = stNoop;
            endcase
        end else begin
            case (lowSel)
                copyM1:  variantState = stCopyM;
                copyK1:  variantState = stCopyK;
                copyN1:  variantState = stCopyN;
                default: variantState = stNoop;
            endcase
        end
    end

endmodule

/* source/microSequencer.sv */
`timescale 1ns/100ps

module microSequencer (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            z,
    input  cu_pkg::cuStateT dispatchState,
    input  cu_pkg::cuStateT variantState,
    output cu_pkg::cuStateT state
);
    import cu_pkg::*;

    cuStateT nextState;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= stNoop;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            // Fetch, then hand over to the decoder
            stFetch1: nextState = stFetch2;
            stFetch2: nextState = stFetch3;
            stFetch3: nextState = dispatchState;

            // Compare cycle, zero flag picks the path
            stJmpM, stJmpK, stJmpN: begin
                if (z) begin
                    nextState = stNoJmp;    // Skip the address word
                end else begin
                    nextState = stJmp2;
                end
            end
            stJmp2: nextState = stJmp3;
            stJmp3: nextState = stJmp4;

            stCopy1: nextState = stCopy2;
            stCopy2: nextState = stCopy3;
            stCopy3: nextState = stCopy4;
            stCopy4: nextState = variantState;    // M1, K1 or N1

            stLoadC1, stLoadC2: nextState = stLoad2;
            stLoad2: nextState = stLoad3;

            stStore1: nextState = stStore2;
            stStore2: nextState = stStore3;

            stAssign1: nextState = stAssign2;
            stAssign2: nextState = variantState;    // C1, C2 or C3

            // Idle and every last step return to fetch
            default: nextState = stFetch1;
        endcase
    end

endmodule

/* testbench/controlUnitTb.sv */
`timescale 1ns/100ps
`include "cu_params.svh"

module controlUnitTb;
    import cu_pkg::*;

    localparam int FIELDS = 10;    // Columns per pattern line
    localparam int MAX_PAT = 64;
    localparam int RESET_CYCLES = 16;
    localparam logic [15:0] MAX_CYC = 16'd12;    // Longest instruction is 8
    localparam logic [`WEN_WIDTH-1:0] IR_ONLY = `WEN_WIDTH'(1) << `WEN_IR;
    localparam logic [`INC_WIDTH-1:0] PC_ONLY = `INC_WIDTH'(1) << `INC_PC;

    logic                  Clk;
    logic                  rstN;
    logic                  z;
    logic [`INS_WIDTH-1:0] ins;
    logic                  iromRead;
    logic                  memRead;
    logic                  memWrite;
    logic [`WEN_WIDTH-1:0] wEn;
    logic                  selAr;
    logic [`BUS_WIDTH-1:0] busSel;
    logic [`INC_WIDTH-1:0] inc;
    logic [`RST_WIDTH-1:0] rst;
    logic [`CMP_WIDTH-1:0] cmpSel;
    aluOpT                 aluOp;

    logic [15:0] patMem [0:FIELDS*MAX_PAT-1];    // Last line of the file is the end marker
    int          numPatterns;
    bit          loaded;
    int          errorCount;
    int          passCount;
    int          failCount;
    string       curTest;

    // Totals over one instruction
    logic [15:0] cycleCnt;
    logic [15:0] wenOr;
    logic [15:0] incOr;
    logic [15:0] rstOr;
    logic [15:0] cmpOr;
    logic [15:0] lastAlu;
    logic [15:0] memRdCnt;
    logic [15:0] memWrCnt;
    logic [15:0] pcIncCnt;

    controlUnit DUT (
        .Clk      (Clk),
        .rstN     (rstN),
        .z        (z),
        .ins      (ins),
        .iromRead (iromRead),
        .memRead  (memRead),
        .memWrite (memWrite),
        .wEn      (wEn),
        .selAr    (selAr),
        .busSel   (busSel),
        .inc      (inc),
        .rst      (rst),
        .cmpSel   (cmpSel),
        .aluOp    (aluOp)
    );

    always #4 Clk = ~Clk;    // 8 ns period

    task automatic reportMismatch(string sig, logic [15:0] expVal, logic [15:0] gotVal);
        $display("error %s: %s expected %h got %h", curTest, sig, expVal, gotVal);
        errorCount++;
    endtask

    // Full control word, zero outside the given fields
    task automatic checkWord(logic expIrom, logic [`WEN_WIDTH-1:0] expWen,
                             logic [`INC_WIDTH-1:0] expInc);
        if (iromRead !== expIrom) reportMismatch("iromRead", 16'(expIrom), 16'(iromRead));
        if (memRead !== 1'b0) reportMismatch("memRead", 16'h0, 16'(memRead));
        if (memWrite !== 1'b0) reportMismatch("memWrite", 16'h0, 16'(memWrite));
        if (selAr !== 1'b0) reportMismatch("selAr", 16'h0, 16'(selAr));
        if (wEn !== expWen) reportMismatch("wEn", 16'(expWen), 16'(wEn));
        if (busSel !== `BUS_NONE) reportMismatch("busSel", 16'(`BUS_NONE), 16'(busSel));
        if (inc !== expInc) reportMismatch("inc", 16'(expInc), 16'(inc));
        if (rst !== '0) reportMismatch("rst", 16'h0, 16'(rst));
        if (cmpSel !== '0) reportMismatch("cmpSel", 16'h0, 16'(cmpSel));
        if (aluOp !== aluNone) reportMismatch("aluOp", 16'(aluNone), 16'(aluOp));
    endtask

    // PC steps over one instruction: the fetch, plus one to skip an operand word
    function automatic logic [15:0] expectedPcSteps(logic [`INS_WIDTH-1:0] insVal,
                                                    logic zVal);
        logic [3:0]  subVal;
        logic [15:0] steps;
        subVal = insVal[3:0];
        steps = 16'd1;
        case (insVal[7:4])
            opJmp:    if (subVal <= 4'd2 && zVal) steps = 16'd2;    // Not taken
            opCopy:   if (subVal <= 4'd2) steps = 16'd2;
            opAssign: if (subVal <= 4'd2) steps = 16'd2;
            default: ;
        endcase
        return steps;
    endfunction

    task automatic addCycle();
        wenOr = wenOr | 16'(wEn);
        incOr = incOr | 16'(inc);
        rstOr = rstOr | 16'(rst);
        cmpOr = cmpOr | 16'(cmpSel);
        if (aluOp != aluNone) lastAlu = 16'(aluOp);
        if (memRead) memRdCnt = memRdCnt + 16'd1;
        if (memWrite) memWrCnt = memWrCnt + 16'd1;
        if (inc[`INC_PC]) pcIncCnt = pcIncCnt + 16'd1;
        cycleCnt = cycleCnt + 16'd1;
    endtask

    task automatic finishTest(int startErrors);
        if (errorCount == startErrors) begin
            passCount++;
            $display("%s: pass", curTest);
        end else begin
            failCount++;
            $display("%s: fail", curTest);
        end
    endtask

    initial begin
        int  p;
        int  base;
        int  startErrors;
        bit  seenFetch;
        bit  lostSync;

        Clk = 1'b0;
        rstN = 1'b0;
        z = 1'b0;
        ins = '0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        lostSync = 1'b0;

        $readmemh("testbench/controlUnit_patterns.txt", patMem);
        numPatterns = 0;
        while (numPatterns < MAX_PAT && patMem[numPatterns * FIELDS] != 16'hffff) begin
            numPatterns++;
        end
        loaded = 1'b1;
        if (numPatterns == 0) begin
            $display("pattern file holds no patterns");
            errorCount++;
        end

        // Idle word through reset, then the first fetch
        curTest = "reset";
        startErrors = errorCount;
        repeat (RESET_CYCLES) begin
            @(negedge Clk);
            checkWord(1'b0, '0, '0);
        end
        rstN = 1'b1;
        @(negedge Clk);
        checkWord(1'b1, '0, '0);
        finishTest(startErrors);

        @(negedge Clk);
        for (p = 0; p < numPatterns && !lostSync; p++) begin
            // DUT is in the second fetch cycle here
            base = p * FIELDS;
            ins = patMem[base][7:0];
            z = patMem[base + 1][0];
            curTest = $sformatf("pattern %0d ins %h z %b", p, ins, z);
            startErrors = errorCount;
            checkWord(1'b0, IR_ONLY, PC_ONLY);
            wenOr = '0;
            incOr = '0;
            rstOr = '0;
            cmpOr = '0;
            lastAlu = '0;
            memRdCnt = '0;
            memWrCnt = '0;
            pcIncCnt = '0;
            cycleCnt = 16'd1;    // First fetch cycle already passed
            addCycle();

            // Next IR load marks the next instruction's second cycle
            seenFetch = 1'b0;
            while (!seenFetch && cycleCnt <= MAX_CYC) begin
                @(negedge Clk);
                if (wEn[`WEN_IR] === 1'b1) begin
                    seenFetch = 1'b1;
                end else begin
                    addCycle();
                end
            end

            if (!seenFetch) begin
                $display("%s: DUT did not return to fetch within %0d cycles", curTest, MAX_CYC);
                errorCount++;
                lostSync = 1'b1;
            end else begin
                if (cycleCnt - 16'd1 !== patMem[base + 2])
                    reportMismatch("cycles", patMem[base + 2], cycleCnt - 16'd1);
                if (wenOr !== patMem[base + 3]) reportMismatch("wEn", patMem[base + 3], wenOr);
                if (incOr !== patMem[base + 4]) reportMismatch("inc", patMem[base + 4], incOr);
                if (rstOr !== patMem[base + 5]) reportMismatch("rst", patMem[base + 5], rstOr);
                if (cmpOr !== patMem[base + 6])
                    reportMismatch("cmpSel", patMem[base + 6], cmpOr);
                if (lastAlu !== patMem[base + 7])
                    reportMismatch("aluOp", patMem[base + 7], lastAlu);
                if (memRdCnt !== patMem[base + 8])
                    reportMismatch("memRead cycles", patMem[base + 8], memRdCnt);
                if (memWrCnt !== patMem[base + 9])
                    reportMismatch("memWrite cycles", patMem[base + 9], memWrCnt);
                if (pcIncCnt !== expectedPcSteps(ins, z))
                    reportMismatch("inc PC cycles", expectedPcSteps(ins, z), pcIncCnt);
            end
            finishTest(startErrors);
        end
        ins = '0;

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passCount + failCount, passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, at most 10 cycles per pattern after reset
    initial begin
        wait (loaded);
        repeat (numPatterns * 10 + RESET_CYCLES) @(posedge Clk);
        $display("timeout: run did not finish within %0d cycles",
                 numPatterns * 10 + RESET_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* testbench/controlUnit_patterns.txt */
// ins z cycles wEnOr incOr rstOr cmpOr aluOp memRdCnt memWrCnt, all hex
// OR columns span the whole instruction, fetch cycles included
00 0 4 0800 20 00 0 0 0 0
10 0 7 1c00 20 00 4 0 0 0
10 1 5 0800 20 00 4 0 0 0
11 0 7 1c00 20 00 2 0 0 0
11 1 5 0800 20 00 2 0 0 0
12 0 7 1c00 20 00 1 0 0 0
12 1 5 0800 20 00 1 0 0 0
20 0 8 0e40 20 00 0 0 1 0
21 1 8 0e20 20 00 0 0 1 0
22 0 8 0e10 20 00 0 0 1 0
30 0 6 0e00 20 00 0 0 1 0
31 0 6 0e00 20 00 0 0 1 0
40 0 6 0e00 20 00 0 0 0 1
50 0 6 0c08 20 00 0 0 0 0
51 0 6 0c04 20 00 0 0 0 0
52 0 6 0c02 20 00 0 0 0 0
60 0 4 0800 20 1f 0 0 0 0
61 0 4 0800 20 02 0 0 0 0
62 0 4 0800 20 04 0 0 0 0
70 0 4 0900 20 00 0 0 0 0
71 0 4 0880 20 00 0 0 0 0
72 0 4 0808 20 00 0 0 0 0
80 0 4 0801 20 00 0 1 0 0
81 0 4 0801 20 00 0 1 0 0
90 0 4 0801 20 00 0 2 0 0
a0 0 4 0801 20 00 0 4 0 0
a1 0 4 0801 20 00 0 4 0 0
a2 0 4 0801 20 00 0 4 0 0
b0 0 4 0800 22 00 0 0 0 0
b1 0 4 0800 21 00 0 0 0 0
b2 0 4 0800 30 00 0 0 0 0
b3 0 4 0800 28 00 0 0 0 0
b4 0 4 0800 24 00 0 0 0 0
13 0 4 0800 20 00 0 0 0 0
23 0 4 0800 20 00 0 0 0 0
32 0 4 0800 20 00 0 0 0 0
41 0 4 0800 20 00 0 0 0 0
53 0 4 0800 20 00 0 0 0 0
63 0 4 0800 20 00 0 0 0 0
b5 0 4 0800 20 00 0 0 0 0
c0 0 4 0800 20 00 0 0 0 0
ff 1 4 0800 20 00 0 0 0 0
ffff ffff ffff ffff ffff ffff ffff ffff ffff ffff

/* testbench/controlUnit_sva.sv */
`timescale 1ns/100ps
`include "cu_params.svh"

module controlUnitSva (
    input logic                  Clk,
    input logic                  rstN,
    input logic                  memRead,
    input logic                  memWrite,
    input logic [`WEN_WIDTH-1:0] wEn,
    input logic [`RST_WIDTH-1:0] rst,
    input cu_pkg::aluOpT         aluOp
);
    import cu_pkg::*;

    // Memory port is read or written, never both
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite high in the same cycle");

    // One register load per cycle
    singleWrite: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0(wEn))
        else $error("more than one wEn bit set: %h", wEn);

    resetNoWrite: assert property (@(posedge Clk) disable iff (!rstN)
        (rst != '0) |-> (wEn == '0))
        else $error("register write during a reset state: wEn %h", wEn);

    // ALU result only goes to AC
    aluToAc: assert property (@(posedge Clk) disable iff (!rstN)
        (aluOp != aluNone) |-> wEn[`WEN_AC])
        else $error("aluOp %h without the AC write enable", aluOp);

endmodule

bind controlUnit controlUnitSva uSva (
    .Clk      (Clk),
    .rstN     (rstN),
    .memRead  (memRead),
    .memWrite (memWrite),
    .wEn      (wEn),
    .rst      (rst),
    .aluOp    (aluOp)
);
